// File: bench/dsp_backend_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "dsp_config.svh"

module dsp_backend_asserts
	import dsp_pkg::*;
(
	input  wire logic                      clk,
	input  wire logic                      rst_n_i,
	input  est_t        [`DSP_LANES-1:0]   estimated_o,
	input  wire logic   [`DSP_LANES-1:0]   checked_o,
	input  wire logic   [`DSP_LANES-1:0]   slice_bits,
	input  chest_t                         h0_i,
	input  chest_t                         h1_i
);

	// every lane holds a defined value out of reset
	for (genvar l = 0; l < `DSP_LANES; l++) begin : g_lane
		a_est_known: assert property (@(posedge clk) disable iff (!rst_n_i)
			!$isunknown(estimated_o[l]))
			else $error("estimated_o lane %0d is unknown", l);
	end

	// still the reset value on the first edge after release
	a_reset_zero: assert property (@(posedge clk)
		(!rst_n_i || $rose(rst_n_i)) |-> checked_o == '0)
		else $error("checked_o not zero around reset");

	// flat channel makes every error tie
	a_follow_slicer: assert property (@(posedge clk) disable iff (!rst_n_i)
		(h0_i == '0 && h1_i == '0) |=> checked_o == $past(slice_bits))
		else $error("checked_o differs from the slicer with h0 and h1 zero");

endmodule : dsp_backend_asserts

bind dsp_backend dsp_backend_asserts i_dsp_backend_asserts (
	.clk         (clk),
	.rst_n_i     (rst_n_i),
	.estimated_o (estimated_o),
	.checked_o   (checked_o),
	.slice_bits  (slice_bits),
	.h0_i        (h0_i),
	.h1_i        (h1_i)
);

`default_nettype wire

// File: bench/dsp_backend_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "dsp_config.svh"

module dsp_backend_tb
	import dsp_pkg::*;
();

	localparam int LANES        = `DSP_LANES;
	localparam int TAPS         = `DSP_FFE_TAPS;
	localparam int PERIOD       = 20;
	localparam int RESET_CYCLES = 8;
	localparam int FLUSH        = 5; // words until checked_o of the last word is out
	localparam int NTESTS       = 6;
	localparam int EST_MAX      = (1 << (`DSP_EST_W - 1)) - 1;
	localparam int EST_MIN      = -(1 << (`DSP_EST_W - 1));

	// code patterns
	localparam int PAT_RANDOM  = 0;
	localparam int PAT_RAMP    = 1;
	localparam int PAT_EXTREME = 2;
	localparam int PAT_NRZ     = 3;

	// two-tap channel behind the nrz pattern
	localparam int              NRZ_H0   = 40;
	localparam int              NRZ_H1   = 20;
	localparam logic [15:0]     NRZ_BITS = 16'b1011_0010_1110_0100;

	typedef struct packed {
		weight_t [TAPS-1:0] weights;
		shift_t             ffe_shift;
		est_t               thresh;
		chest_t             h0;
		chest_t             h1;
		shift_t             mlsd_shift;
		logic [1:0]         pattern;
		logic [7:0]         nwords;
		logic               need_fix; // pattern must make the checker overrule the slicer
	} test_row_t;

	logic                    clk;
	logic                    rst_n_i;
	code_t   [LANES-1:0]     codes_i;
	weight_t [TAPS-1:0]      weights_i;
	shift_t                  ffe_shift_i;
	est_t                    thresh_i;
	chest_t                  h0_i;
	chest_t                  h1_i;
	shift_t                  mlsd_shift_i;
	est_t    [LANES-1:0]     estimated_o;
	logic    [LANES-1:0]     checked_o;

	test_row_t tests [NTESTS];
	string     test_name [NTESTS];
	test_row_t cur;
	int        samples [$]; // serial code stream of the running test
	int        seed;
	int        pass_count;
	int        fail_count;
	int        test_errors;

	dsp_backend i_dsp_backend (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.codes_i      (codes_i),
		.weights_i    (weights_i),
		.ffe_shift_i  (ffe_shift_i),
		.thresh_i     (thresh_i),
		.h0_i         (h0_i),
		.h1_i         (h1_i),
		.mlsd_shift_i (mlsd_shift_i),
		.estimated_o  (estimated_o),
		.checked_o    (checked_o)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	function automatic test_row_t make_row(input int w0, input int w1, input int w2,
			input int fsh, input int thr, input int h0, input int h1, input int msh,
			input int pat, input int nw, input bit fix);
		test_row_t r;
		r.weights[0] = weight_t'(w0);
		r.weights[1] = weight_t'(w1);
		r.weights[2] = weight_t'(w2);
		r.ffe_shift  = shift_t'(fsh);
		r.thresh     = est_t'(thr);
		r.h0         = chest_t'(h0);
		r.h1         = chest_t'(h1);
		r.mlsd_shift = shift_t'(msh);
		r.pattern    = pat[1:0];
		r.nwords     = nw[7:0];
		r.need_fix   = fix;
		return r;
	endfunction

	function automatic int sgn(input bit b);
		return b ? 1 : -1;
	endfunction

	function automatic int pattern_code(input int pat, input int n);
		int rnd;
		case (pat)
			PAT_RAMP:    return ((n * 29 + 7) % 256) - 128;
			PAT_EXTREME: return ((n / 3) % 2 == 0) ? 127 : -128; // runs of three
			PAT_NRZ:     return NRZ_H0 * sgn(NRZ_BITS[n % 16]) +
			                    NRZ_H1 * sgn(NRZ_BITS[(n + 15) % 16]);
			default: begin
				rnd = $random(seed);
				return (rnd & 255) - 128;
			end
		endcase
	endfunction

	// samples before the first word are zero, as the history resets
	function automatic int code_at(input int n);
		if (n < 0 || n >= samples.size())
			return 0;
		return samples[n];
	endfunction

	function automatic int model_est(input int n);
		int acc;
		acc = 0;
		for (int k = 0; k < TAPS; k++) begin
			acc = acc + int'($signed(cur.weights[k])) * code_at(n - k);
		end
		acc = acc >>> cur.ffe_shift;
		if (acc > EST_MAX)
			return EST_MAX;
		if (acc < EST_MIN)
			return EST_MIN;
		return acc;
	endfunction

	function automatic bit model_bit(input int n);
		return model_est(n) >= int'($signed(cur.thresh));
	endfunction

	function automatic bit model_check(input int n);
		int h0;
		int h1;
		int isi;
		int d1;
		int d0;
		int err1;
		int err0;
		h0   = $signed(cur.h0);
		h1   = $signed(cur.h1);
		isi  = h1 * sgn(model_bit(n - 1));
		d1   = code_at(n) - (isi + h0);
		d0   = code_at(n) - (isi - h0);
		err1 = ((d1 < 0) ? -d1 : d1) >> cur.mlsd_shift;
		err0 = ((d0 < 0) ? -d0 : d0) >> cur.mlsd_shift;
		if (err1 < err0)
			return 1'b1;
		if (err0 < err1)
			return 1'b0;
		return model_bit(n); // tie
	endfunction

	task automatic check_value(input string what, input int idx, input int got, input int exp);
		assert (got == exp) begin
			pass_count++;
		end else begin
			$display("Error at %0t: %s %0d is %0d, expected %0d", $time, what, idx, got, exp);
			fail_count++;
			test_errors++;
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#2;
		rst_n_i      = 1'b0;
		codes_i      = '0;
		weights_i    = cur.weights;
		ffe_shift_i  = cur.ffe_shift;
		thresh_i     = cur.thresh;
		h0_i         = cur.h0;
		h1_i         = cur.h1;
		mlsd_shift_i = cur.mlsd_shift;
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst_n_i = 1'b1;
		// nothing new has reached the outputs yet
		for (int l = 0; l < LANES; l++) begin
			check_value("estimated_o after reset, lane", l, $signed(estimated_o[l]), 0);
			check_value("checked_o after reset, lane", l, checked_o[l], 0);
		end
	endtask

	task automatic run_test(input int t);
		int total;
		int fixes;
		int n;
		int code;
		test_errors = 0;
		fixes       = 0;
		samples.delete();
		cur = tests[t];
		apply_reset();
		total = cur.nwords + FLUSH;
		for (int i = 0; i < total; i++) begin
			@(posedge clk);
			#2;
			if (i >= 3 && i - 3 < cur.nwords) begin // estimate 2 edges after capture
				for (int l = 0; l < LANES; l++) begin
					n = (i - 3) * LANES + l;
					check_value("estimated_o of sample", n, $signed(estimated_o[l]), model_est(n));
				end
			end
			if (i >= 5 && i - 5 < cur.nwords) begin
				for (int l = 0; l < LANES; l++) begin
					n = (i - 5) * LANES + l;
					check_value("checked_o of sample", n, checked_o[l], model_check(n));
					if (model_check(n) != model_bit(n))
						fixes++;
				end
			end
			for (int l = 0; l < LANES; l++) begin
				code = (i < cur.nwords) ? pattern_code(cur.pattern, i * LANES + l) : 0;
				samples.push_back(code);
				codes_i[l] = code_t'(code);
			end
		end
		if (cur.need_fix) begin
			assert (fixes > 0) else begin
				$display("test %0d: the checker never overruled the slicer, so no correction was seen",
					t);
				fail_count++;
				test_errors++;
			end
		end
		$display("test %0d (%s) finished with %0d errors", t, test_name[t], test_errors);
	endtask

	initial begin : watchdog
		int cycles;
		#1;
		cycles = 0;
		for (int t = 0; t < NTESTS; t++) begin
			cycles = cycles + tests[t].nwords + FLUSH + RESET_CYCLES + 10;
		end
		#(cycles * PERIOD);
		$display("timeout: the run hung and did not end within %0d cycles", cycles);
		$display("Something failed");
		$finish;
	end

	initial begin
		seed         = 74069;
		pass_count   = 0;
		fail_count   = 0;
		test_errors  = 0;
		rst_n_i      = 1'b0;
		codes_i      = '0;
		weights_i    = '0;
		ffe_shift_i  = '0;
		thresh_i     = '0;
		h0_i         = '0;
		h1_i         = '0;
		mlsd_shift_i = '0;

		// weights w0 w1 w2, ffe shift, threshold, h0, h1, mlsd shift, pattern, words
		tests[0] = make_row(1, 0, 0, 0, 0, 0, 0, 0, PAT_RANDOM, 24, 1'b0);
		test_name[0] = "identity ffe";
		tests[1] = make_row(5, -3, 2, 3, 10, 30, -12, 2, PAT_RANDOM, 32, 1'b0);
		test_name[1] = "multi-tap ffe across words";
		tests[2] = make_row(127, 127, 127, 0, 0, 50, 25, 0, PAT_EXTREME, 16, 1'b0);
		test_name[2] = "estimate saturation";
		tests[3] = make_row(3, -2, 1, 2, -37, 0, 0, 1, PAT_RANDOM, 32, 1'b0);
		test_name[3] = "slicer threshold";
		tests[4] = make_row(1, 0, 0, 0, 30, NRZ_H0, NRZ_H1, 1, PAT_NRZ, 24, 1'b1);
		test_name[4] = "checker correction";
		tests[5] = make_row(-100, 90, -60, 5, -5, -70, 45, 3, PAT_RAMP, 20, 1'b0);
		test_name[5] = "mixed ramp";

		for (int t = 0; t < NTESTS; t++) begin
			run_test(t);
		end

		$display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule : dsp_backend_tb

`default_nettype wire

// File: dsp_backend.f
+incdir+hw
hw/dsp_pkg.sv
hw/code_history.sv
hw/ffe_filter.sv
hw/bit_slicer.sv
hw/mlsd_checker.sv
hw/dsp_backend.sv
bench/dsp_backend_asserts.sv
bench/dsp_backend_tb.sv

// File: hw/bit_slicer.sv
`timescale 1ns/1ps
`default_nettype none

`include "dsp_config.svh"

module bit_slicer
	import dsp_pkg::*;
(
	input  wire logic                      clk,
	input  wire logic                      rst_n_i,
	input  est_t        [`DSP_LANES-1:0]   est_i,
	input  est_t                           thresh_i,
	output logic        [`DSP_LANES-1:0]   bits_o,
	output logic                           prev_bit_o // last lane of the word before bits_o
);

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			bits_o     <= '0;
			prev_bit_o <= 1'b0;
		end else begin
			for (int l = 0; l < `DSP_LANES; l++) begin
				bits_o[l] <= ($signed(est_i[l]) >= $signed(thresh_i));
			end
			prev_bit_o <= bits_o[`DSP_LANES-1];
		end
	end

endmodule : bit_slicer

`default_nettype wire

// File: hw/code_history.sv
`timescale 1ns/1ps
`default_nettype none

`include "dsp_config.svh"

module code_history
	import dsp_pkg::*;
(
	input  wire logic                         clk,
	input  wire logic                         rst_n_i,
	input  code_t       [`DSP_LANES-1:0]      codes_i,
	output code_t       [2*`DSP_LANES-1:0]    window_o,
	output code_t       [`DSP_LANES-1:0]      codes_q_o
);

	code_t [`DSP_LANES-1:0] prev_q; // word before codes_q_o

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			codes_q_o <= '0;
			prev_q    <= '0;
		end else begin
			codes_q_o <= codes_i;
			prev_q    <= codes_q_o;
		end
	end

	// flat window, index 0 is the oldest sample
	// lanes of the current word sit at DSP_LANES and above
	assign window_o = {codes_q_o, prev_q};

endmodule : code_history

`default_nettype wire

// File: hw/dsp_backend.sv
`timescale 1ns/1ps
`default_nettype none

`include "dsp_config.svh"

module dsp_backend
	import dsp_pkg::*;
(
	input  wire logic                         clk,
	input  wire logic                         rst_n_i,
	input  code_t       [`DSP_LANES-1:0]      codes_i,

	// static configuration, hold during a run
	input  weight_t     [`DSP_FFE_TAPS-1:0]   weights_i,
	input  shift_t                            ffe_shift_i,
	input  est_t                              thresh_i,
	input  chest_t                            h0_i,
	input  chest_t                            h1_i,
	input  shift_t                            mlsd_shift_i,

	output est_t        [`DSP_LANES-1:0]      estimated_o,
	output logic        [`DSP_LANES-1:0]      checked_o
);

	code_t [2*`DSP_LANES-1:0] window;
	code_t [`DSP_LANES-1:0]   codes_q;
	logic  [`DSP_LANES-1:0]   slice_bits;
	logic                     slice_prev;

	code_history i_code_history (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.codes_i   (codes_i),
		.window_o  (window),
		.codes_q_o (codes_q)
	);

	ffe_filter i_ffe_filter (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.window_i    (window),
		.weights_i   (weights_i),
		.ffe_shift_i (ffe_shift_i),
		.est_o       (estimated_o)
	);

	bit_slicer i_bit_slicer (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.est_i      (estimated_o),
		.thresh_i   (thresh_i),
		.bits_o     (slice_bits),
		.prev_bit_o (slice_prev)
	);

	mlsd_checker i_mlsd_checker (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.codes_i      (codes_q),
		.bits_i       (slice_bits),
		.prev_bit_i   (slice_prev),
		.h0_i         (h0_i),
		.h1_i         (h1_i),
		.mlsd_shift_i (mlsd_shift_i),
		.checked_o    (checked_o)
	);

endmodule : dsp_backend

`default_nettype wire

// File: hw/dsp_config.svh
`ifndef DSP_CONFIG_SVH
`define DSP_CONFIG_SVH

// samples per clock word, lane 0 oldest
`define DSP_LANES 4

// signed adc code
`define DSP_CODE_W 8

// ffe coefficients
`define DSP_WEIGHT_W 8
`define DSP_FFE_TAPS 3 // at most DSP_LANES + 1

// equalized estimate, saturated
`define DSP_EST_W 10

// right shift amounts for ffe and checker
`define DSP_SHIFT_W 4

// channel estimate taps h0, h1
`define DSP_CHEST_W 8

`endif

// File: hw/dsp_pkg.sv
`default_nettype none

`include "dsp_config.svh"

package dsp_pkg;

	// raw adc sample
	typedef logic signed [`DSP_CODE_W-1:0] code_t;

	// ffe coefficient
	typedef logic signed [`DSP_WEIGHT_W-1:0] weight_t;

	// ffe output and slicer threshold
	typedef logic signed [`DSP_EST_W-1:0] est_t;

	// channel estimate tap
	typedef logic signed [`DSP_CHEST_W-1:0] chest_t;

	// arithmetic right shift amount
	typedef logic [`DSP_SHIFT_W-1:0] shift_t;

endpackage : dsp_pkg

`default_nettype wire

// File: hw/ffe_filter.sv
`timescale 1ns/1ps
`default_nettype none

`include "dsp_config.svh"

module ffe_filter
	import dsp_pkg::*;
(
	input  wire logic                          clk,
	input  wire logic                          rst_n_i,
	input  code_t       [2*`DSP_LANES-1:0]     window_i,
	input  weight_t     [`DSP_FFE_TAPS-1:0]    weights_i,
	input  shift_t                             ffe_shift_i,
	output est_t        [`DSP_LANES-1:0]       est_o
);

	localparam int LANES  = `DSP_LANES;
	localparam int TAPS   = `DSP_FFE_TAPS;
	localparam int PROD_W = `DSP_CODE_W + `DSP_WEIGHT_W;
	localparam int SUM_W  = PROD_W + $clog2(TAPS + 1);

	localparam logic signed [SUM_W-1:0] EST_MAX = (1 <<< (`DSP_EST_W - 1)) - 1;
	localparam logic signed [SUM_W-1:0] EST_MIN = -(1 <<< (`DSP_EST_W - 1));

	// taps reach back at most one word
	if (TAPS > LANES + 1) begin : g_tap_check
		$error("ffe_filter: DSP_FFE_TAPS exceeds DSP_LANES + 1");
	end

	logic signed [PROD_W-1:0] prod_q [LANES][TAPS];
	est_t        [LANES-1:0]  est_d;

	// stage one, every lane times every tap
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			prod_q <= '{default: '0};
		end else begin
			for (int l = 0; l < LANES; l++) begin
				for (int k = 0; k < TAPS; k++) begin
					// sample n-k of lane l
					prod_q[l][k] <= $signed(window_i[LANES + l - k]) * $signed(weights_i[k]);
				end
			end
		end
	end

	// stage two, sum then shift then clamp
	always_comb begin
		logic signed [SUM_W-1:0] acc;
		logic signed [SUM_W-1:0] shifted;
		for (int l = 0; l < LANES; l++) begin
			acc = '0;
			for (int k = 0; k < TAPS; k++) begin
				acc = acc + prod_q[l][k];
			end
			shifted = acc >>> ffe_shift_i;
			if (shifted > EST_MAX) begin
				est_d[l] = EST_MAX[`DSP_EST_W-1:0];
			end else if (shifted < EST_MIN) begin
				est_d[l] = EST_MIN[`DSP_EST_W-1:0];
			end else begin
				est_d[l] = shifted[`DSP_EST_W-1:0];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			est_o <= '0;
		end else begin
			est_o <= est_d;
		end
	end

endmodule : ffe_filter

`default_nettype wire

// File: hw/mlsd_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "dsp_config.svh"

module mlsd_checker
	import dsp_pkg::*;
(
	input  wire logic                      clk,
	input  wire logic                      rst_n_i,
	input  code_t       [`DSP_LANES-1:0]   codes_i,
	input  wire logic   [`DSP_LANES-1:0]   bits_i,
	input  wire logic                      prev_bit_i,
	input  chest_t                         h0_i,
	input  chest_t                         h1_i,
	input  shift_t                         mlsd_shift_i,
	output logic        [`DSP_LANES-1:0]   checked_o
);

	localparam int LANES = `DSP_LANES;
	localparam int DLY   = 3; // ffe 2 + slicer 1
	// h0 + h1 and code - expected both fit with margin
	localparam int ERR_W = `DSP_CHEST_W + 3;

	code_t [LANES-1:0] code_dly_q [DLY];
	logic  [LANES-1:0] bit_ext;
	logic  [LANES-1:0] dec_c;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			code_dly_q <= '{default: '0};
		end else begin
			code_dly_q[0] <= codes_i;
			for (int d = 1; d < DLY; d++) begin
				code_dly_q[d] <= code_dly_q[d-1];
			end
		end
	end

	// bit_ext[l] is the symbol before lane l
	assign bit_ext = {bits_i[LANES-2:0], prev_bit_i};

	always_comb begin
		logic signed [ERR_W-1:0] h0_ext;
		logic signed [ERR_W-1:0] h1_ext;
		logic signed [ERR_W-1:0] isi;
		logic signed [ERR_W-1:0] code_ext;
		logic signed [ERR_W-1:0] diff1;
		logic signed [ERR_W-1:0] diff0;
		logic        [ERR_W-1:0] err1;
		logic        [ERR_W-1:0] err0;
		h0_ext = h0_i;
		h1_ext = h1_i;
		for (int l = 0; l < LANES; l++) begin
			isi      = bit_ext[l] ? h1_ext : -h1_ext;
			code_ext = $signed(code_dly_q[DLY-1][l]);
			diff1    = code_ext - (isi + h0_ext); // hypothesis b = 1
			diff0    = code_ext - (isi - h0_ext); // hypothesis b = 0
			err1     = diff1[ERR_W-1] ? -diff1 : diff1;
			err0     = diff0[ERR_W-1] ? -diff0 : diff0;
			err1     = err1 >> mlsd_shift_i;
			err0     = err0 >> mlsd_shift_i;
			if (err1 < err0) begin
				dec_c[l] = 1'b1;
			end else if (err0 < err1) begin
				dec_c[l] = 1'b0;
			end else begin
				dec_c[l] = bits_i[l]; // tie keeps slicer
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			checked_o <= '0;
		end else begin
			checked_o <= dec_c;
		end
	end

endmodule : mlsd_checker

`default_nettype wire
